// File: rtl/mem_bus_pkg.sv
// bus-side package: address and bus widths, lane count, access size enum, bus beat struct
`default_nettype none

package mem_bus_pkg;

    localparam int ADDR_W = 24;    // byte address space
    localparam int BUS_W  = 16;
    localparam int BYTE_W = 8;
    localparam int LANES  = BUS_W / BYTE_W;

    // cached address when nothing is cached
    localparam logic [ADDR_W-1:0] NO_ADDR = '1;

    // operand width of one access
    typedef enum logic [1:0] {
        sz_byte,
        sz_word,
        sz_quad
    } acc_size_e;

    // everything driven onto the bus for one beat
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BUS_W-1:0]  din;
        logic [LANES-1:0]  we;     // bit 0 is the even byte
        logic              rd;
    } bus_beat_t;

endpackage

`default_nettype wire

// File: rtl/mem_uop_pkg.sv
// micro-operation package: operand width, address source, request and register load types
`default_nettype none

package mem_uop_pkg;

    localparam int DATA_W = 32;    // operand register width

    // where the effective address comes from
    typedef enum logic [1:0] {
        src_pc,
        src_da,
        src_sp,
        src_ea
    } ea_src_e;

    // register written by a load strobe
    typedef enum logic [1:0] {
        r_pc,
        r_da,
        r_sp,
        r_md
    } reg_sel_e;

    // levels from the sequencer
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        mem_bus_pkg::acc_size_e size;
        ea_src_e                src;
        logic                   da2ea;    // copy da into ea
    } mem_req_t;

    // single-cycle register write
    typedef struct packed {
        logic              load;
        reg_sel_e          sel;
        logic [DATA_W-1:0] value;
    } reg_load_t;

endpackage

`default_nettype wire

// File: rtl/operand_regs.sv
// operand register block: pc, da, xsp and md with load port and pc advance after fetches
`default_nettype none

module operand_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  mem_uop_pkg::reg_load_t         reg_load,
    input  logic                           fetch_done,
    input  mem_bus_pkg::acc_size_e         fetch_size,
    output logic [mem_bus_pkg::ADDR_W-1:0] pc,
    output logic [mem_uop_pkg::DATA_W-1:0] da,
    output logic [mem_uop_pkg::DATA_W-1:0] xsp,
    output logic [mem_uop_pkg::DATA_W-1:0] md
);

    import mem_bus_pkg::*;
    import mem_uop_pkg::*;

    logic [ADDR_W-1:0] pc_step;

    // bytes consumed by the fetch
    always_comb begin
        case (fetch_size)
            sz_byte: pc_step = ADDR_W'(1);
            sz_word: pc_step = ADDR_W'(2);
            default: pc_step = ADDR_W'(4);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc  <= '0;
            da  <= '0;
            xsp <= '0;
            md  <= '0;
        end else begin
            if (fetch_done) begin
                pc <= pc + pc_step;
            end
            if (reg_load.load) begin
                case (reg_load.sel)
                    r_pc:    pc  <= reg_load.value[ADDR_W-1:0];    // upper byte dropped
                    r_da:    da  <= reg_load.value;
                    r_sp:    xsp <= reg_load.value;
                    default: md  <= reg_load.value;
                endcase
            end
        end
    end

    // sequencer never reloads pc in the cycle a fetch retires
    a_no_pc_clash: assert property (@(posedge clk) disable iff (rst)
        !(fetch_done && reg_load.load && reg_load.sel == r_pc));

endmodule

`default_nettype wire

// File: rtl/mem_access.sv
// memory access unit: address select, multi-beat read and write sequences, read cache, ea
`default_nettype none

module mem_access (
    input  logic                           clk,
    input  logic                           rst,
    input  mem_uop_pkg::mem_req_t          req,
    input  logic [mem_bus_pkg::ADDR_W-1:0] pc,
    input  logic [mem_uop_pkg::DATA_W-1:0] da,
    input  logic [mem_uop_pkg::DATA_W-1:0] xsp,
    input  logic [mem_uop_pkg::DATA_W-1:0] md,
    input  logic [mem_bus_pkg::BUS_W-1:0]  bus_dout,
    input  logic                           bus_busy,
    output mem_bus_pkg::bus_beat_t         beat,
    output logic [mem_uop_pkg::DATA_W-1:0] mdata,
    output logic [mem_uop_pkg::DATA_W-1:0] ea,
    output logic                           busy,
    output logic                           fetch_done,
    output mem_bus_pkg::acc_size_e         fetch_size
);

    import mem_bus_pkg::*;
    import mem_uop_pkg::*;

    localparam int WBUF_W = 3 * BUS_W;    // md shifted by one byte spans three beats

    // lanes used by beat k of an access
    function automatic logic [LANES-1:0] lane_mask(acc_size_e s, logic odd, logic [1:0] k);
        logic [LANES-1:0] m;
        case (k)
            2'd0:    m = odd ? 2'b10 : ((s == sz_byte) ? 2'b01 : 2'b11);
            2'd1:    m = (s == sz_quad) ? 2'b11 : 2'b01;
            default: m = 2'b01;
        endcase
        return m;
    endfunction

    // index of the final beat: 1, 2 or 3 beats per access
    function automatic logic [1:0] last_step(acc_size_e s, logic odd);
        logic [1:0] k;
        case (s)
            sz_byte: k = 2'd0;
            sz_word: k = odd ? 2'd1 : 2'd0;
            default: k = odd ? 2'd2 : 2'd1;
        endcase
        return k;
    endfunction

    logic [ADDR_W-1:0] nx_addr;
    logic [ADDR_W-1:0] ca;         // cached read address
    acc_size_e         csz;        // cached read size
    logic [ADDR_W-1:0] base;       // address of the first beat
    acc_size_e         sz;
    logic              from_pc;
    logic [2:0]        wp;         // one-hot write step
    logic [2:0]        rp;         // one-hot read step
    logic [WBUF_W-1:0] wbuf;
    logic [WBUF_W-1:0] nx_wbuf;
    logic              rd_l;
    logic              wr_l;
    logic              rd_edge;
    logic              wr_edge;
    logic              hit;
    logic              work;
    logic              start_wr;
    logic              start_rd;
    logic              accept;
    logic              odd;
    logic [1:0]        k;
    logic [1:0]        delta;
    logic [1:0]        idx0;
    logic [LANES-1:0]  lanes;

    always_comb begin
        case (req.src)
            src_da:  nx_addr = da[ADDR_W-1:0];
            src_sp:  nx_addr = xsp[ADDR_W-1:0];
            src_ea:  nx_addr = ea[ADDR_W-1:0];
            default: nx_addr = pc;
        endcase
    end

    // odd start moves md up one lane
    assign nx_wbuf = nx_addr[0] ? {8'h00, md, 8'h00} : {16'h0000, md};

    assign rd_edge  = req.rd && !rd_l;
    assign wr_edge  = req.wr && !wr_l;
    assign hit      = (nx_addr == ca) && (req.size == csz);
    assign work     = (wp != '0) || (rp != '0);
    assign start_wr = !work && wr_edge;
    assign start_rd = !work && rd_edge && !req.wr && !hit;
    assign busy     = work || start_wr || start_rd;
    assign accept   = work && !bus_busy;

    assign odd   = base[0];
    assign k     = (wp[2] || rp[2]) ? 2'd2 : ((wp[1] || rp[1]) ? 2'd1 : 2'd0);
    assign delta = (k == 2'd2) ? 2'd3 : ((k == 2'd1) ? (odd ? 2'd1 : 2'd2) : 2'd0);
    assign lanes = lane_mask(sz, odd, k);
    assign idx0  = delta - {1'b0, beat.addr[0]};    // result byte on the even lane

    assign beat.addr  = base + ADDR_W'(delta);
    assign beat.din   = wbuf[{k, 4'b0000} +: BUS_W];
    assign beat.we    = (wp != '0) ? lanes : '0;
    assign beat.rd    = rp != '0;
    assign fetch_size = sz;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_l       <= 1'b0;
            wr_l       <= 1'b0;
            ca         <= NO_ADDR;
            csz        <= sz_byte;
            base       <= '0;
            sz         <= sz_byte;
            from_pc    <= 1'b0;
            wp         <= '0;
            rp         <= '0;
            mdata      <= '0;
            ea         <= '0;
            fetch_done <= 1'b0;
        end else begin
            rd_l       <= req.rd;
            wr_l       <= req.wr;
            fetch_done <= 1'b0;
            if (req.da2ea) begin
                ea <= da;
            end
            if (start_wr) begin
                base <= nx_addr;
                sz   <= req.size;
                ca   <= NO_ADDR;    // written bytes may overlap the cached read
                wp   <= 3'b001;
            end else if (start_rd) begin
                base    <= nx_addr;
                sz      <= req.size;
                ca      <= nx_addr;
                csz     <= req.size;
                from_pc <= req.src == src_pc;
                mdata   <= '0;      // upper bytes stay zero for short reads
                rp      <= 3'b001;
            end else if (accept) begin
                if (rp != '0) begin
                    for (int i = 0; i < LANES; i++) begin
                        if (lanes[i]) begin
                            mdata[{idx0 + 2'(i), 3'b000} +: BYTE_W] <=
                                bus_dout[BYTE_W*i +: BYTE_W];
                        end
                    end
                end
                if (k == last_step(sz, odd)) begin
                    fetch_done <= (rp != '0) && from_pc;
                    wp         <= '0;
                    rp         <= '0;
                end else begin
                    wp <= wp << 1;
                    rp <= rp << 1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_wr) begin
            wbuf <= nx_wbuf;
        end
    end

    a_rd_we_excl: assert property (@(posedge clk) disable iff (rst)
        !(beat.rd && (beat.we != '0)));

    // wait states from the bus must not disturb the beat
    a_beat_hold: assert property (@(posedge clk) disable iff (rst)
        bus_busy |=> $stable(beat));

    a_fetch_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_done |=> !fetch_done);

endmodule

`default_nettype wire

// File: rtl/wait_state_gen.sv
// wait-state generator: holds bus_busy for WAIT_CYCLES cycles on each new bus beat
`default_nettype none

module wait_state_gen #(
    parameter int WAIT_CYCLES = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  mem_bus_pkg::bus_beat_t beat,
    output logic                   bus_busy
);

    import mem_bus_pkg::*;

    localparam int CNT_W = (WAIT_CYCLES < 2) ? 1 : $clog2(WAIT_CYCLES);

    bus_beat_t        last;      // beat seen one cycle earlier
    logic [CNT_W-1:0] cnt;       // wait cycles still to go after the first
    logic             active;
    logic             fresh;

    assign active   = beat.rd || (beat.we != '0);
    assign fresh    = active && (beat != last);
    assign bus_busy = (WAIT_CYCLES > 0) && (fresh || (cnt != '0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last <= '0;
            cnt  <= '0;
        end else begin
            last <= beat;
            if (fresh && (WAIT_CYCLES > 1)) begin
                cnt <= CNT_W'(WAIT_CYCLES - 1);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // requester keeps its strobe up through every wait cycle
    a_busy_needs_strobe: assert property (@(posedge clk) disable iff (rst)
        bus_busy |-> active);

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
// memory subsystem top: operand registers, memory access unit and wait-state generator
`default_nettype none

module mem_subsys_top #(
    parameter int WAIT_CYCLES = 1
) (
    input  logic                           clk,
    input  logic                           rst,
    input  mem_uop_pkg::mem_req_t          req,
    input  mem_uop_pkg::reg_load_t         reg_load,
    input  logic [mem_bus_pkg::BUS_W-1:0]  bus_dout,
    output mem_bus_pkg::bus_beat_t         beat,
    output logic [mem_uop_pkg::DATA_W-1:0] mdata,
    output logic [mem_uop_pkg::DATA_W-1:0] ea,
    output logic [mem_bus_pkg::ADDR_W-1:0] pc,
    output logic                           busy
);

    import mem_bus_pkg::*;
    import mem_uop_pkg::*;

    logic [DATA_W-1:0] da;
    logic [DATA_W-1:0] xsp;
    logic [DATA_W-1:0] md;          // write data
    logic              fetch_done;
    acc_size_e         fetch_size;
    logic              bus_busy;    // wait states from the bus

    operand_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_load   (reg_load),
        .fetch_done (fetch_done),
        .fetch_size (fetch_size),
        .pc         (pc),
        .da         (da),
        .xsp        (xsp),
        .md         (md)
    );

    mem_access i_mem (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .pc         (pc),
        .da         (da),
        .xsp        (xsp),
        .md         (md),
        .bus_dout   (bus_dout),
        .bus_busy   (bus_busy),
        .beat       (beat),
        .mdata      (mdata),
        .ea         (ea),
        .busy       (busy),
        .fetch_done (fetch_done),
        .fetch_size (fetch_size)
    );

    wait_state_gen #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) i_wait (
        .clk      (clk),
        .rst      (rst),
        .beat     (beat),
        .bus_busy (bus_busy)
    );

endmodule

`default_nettype wire

// File: tb/sram_model.sv
// word-wide SRAM model of 64 KiB with byte lane enables and combinational read data
`default_nettype none

module sram_model (
    input  logic                          clk,
    input  mem_bus_pkg::bus_beat_t        beat,
    input  logic                          bus_busy,
    output logic [mem_bus_pkg::BUS_W-1:0] bus_dout
);

    timeunit 1ns;
    timeprecision 100ps;

    import mem_bus_pkg::*;

    logic [BUS_W-1:0] mem [0:32767];    // indexed by addr[15:1]

    // every byte address gets its own value
    function automatic logic [7:0] fill_byte(logic [15:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    initial begin
        for (int i = 0; i < 32768; i++) begin
            mem[i] = {fill_byte(16'(2 * i + 1)), fill_byte(16'(2 * i))};
        end
    end

    assign bus_dout = mem[beat.addr[15:1]];

    always @(posedge clk) begin
        if (!bus_busy) begin
            if (beat.we[0]) begin
                mem[beat.addr[15:1]][7:0] <= beat.din[7:0];     // even byte
            end
            if (beat.we[1]) begin
                mem[beat.addr[15:1]][15:8] <= beat.din[15:8];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_mem_subsys.sv
// memory subsystem testbench with clock, reset, reference memory, directed tests and watchdog
`default_nettype none

module tb_mem_subsys;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_bus_pkg::*;
    import mem_uop_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int WAIT_CYCLES  = 1;
    localparam int N_TEST_CALLS = 21;    // 6 writes, 12 reads, cache, fetch, da2ea

    logic              clk = 1'b0;
    logic              rst;
    mem_req_t          req;
    reg_load_t         reg_load;
    logic [BUS_W-1:0]  bus_dout;
    bus_beat_t         beat;
    logic [DATA_W-1:0] mdata;
    logic [DATA_W-1:0] ea;
    logic [ADDR_W-1:0] pc;
    logic              busy;

    logic [7:0]        ref_mem [0:65535];
    logic [ADDR_W-1:0] cached_addr = NO_ADDR;    // model of the read cache
    acc_size_e         cached_size = sz_byte;
    logic [DATA_W-1:0] last_mdata  = '0;
    logic [ADDR_W-1:0] exp_pc      = '0;
    logic [31:0]       rnd_state   = 32'h451a;

    mem_subsys_top #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .reg_load (reg_load),
        .bus_dout (bus_dout),
        .beat     (beat),
        .mdata    (mdata),
        .ea       (ea),
        .pc       (pc),
        .busy     (busy)
    );

    sram_model i_sram (
        .clk      (clk),
        .beat     (beat),
        .bus_busy (i_dut.bus_busy),
        .bus_dout (bus_dout)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [7:0] fill_byte(logic [15:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    function automatic int size_bytes(acc_size_e s);
        return (s == sz_byte) ? 1 : ((s == sz_word) ? 2 : 4);
    endfunction

    // an odd start costs one more beat for word and quad
    function automatic int beat_count(acc_size_e s, logic odd);
        return (s == sz_byte) ? 1 : ((s == sz_word) ? (odd ? 2 : 1) : (odd ? 3 : 2));
    endfunction

    function automatic logic [7:0] sram_byte(logic [15:0] a);
        logic [15:0] w;
        w = i_sram.mem[a[15:1]];
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic load_reg(reg_sel_e sel, logic [31:0] value);
        next_cycle();
        reg_load.load  = 1'b1;
        reg_load.sel   = sel;
        reg_load.value = value;
        next_cycle();
        reg_load.load = 1'b0;
    endtask

    // raise the level, count beats and busy cycles until busy falls, then lower it
    task automatic run_access(logic is_write, acc_size_e size, ea_src_e src,
                              output int beats, output int busy_cycles);
        bus_beat_t prev;
        logic      prev_act;
        logic      act;
        next_cycle();
        req.size = size;
        req.src  = src;
        req.wr   = is_write;
        req.rd   = !is_write;
        beats       = 0;
        busy_cycles = 0;
        prev_act    = 1'b0;
        prev        = '0;
        do begin
            @(negedge clk);
            act = beat.rd || (beat.we != '0);
            if (act && (!prev_act || beat != prev)) begin
                beats++;    // new beat on the bus
            end
            prev     = beat;
            prev_act = act;
            if (busy) begin
                busy_cycles++;
            end
        end while (busy);
        next_cycle();
        req.rd = 1'b0;
        req.wr = 1'b0;
    endtask

    task automatic write_check(acc_size_e size, logic [ADDR_W-1:0] addr, logic [31:0] data);
        int          beats;
        int          busy_cycles;
        int          exp_beats;
        logic [15:0] a;
        exp_beats = beat_count(size, addr[0]);
        load_reg(r_da, {8'h00, addr});
        load_reg(r_md, data);
        run_access(1'b1, size, src_da, beats, busy_cycles);
        check("write beats", beats, exp_beats);
        check("write busy cycles", busy_cycles, 1 + exp_beats * (1 + WAIT_CYCLES));
        for (int i = 0; i < size_bytes(size); i++) begin
            ref_mem[16'(addr + ADDR_W'(i))] = data[8*i +: 8];
        end
        cached_addr = NO_ADDR;
        for (int j = -2; j < 6; j++) begin    // written bytes and their neighbours
            a = addr[15:0] + 16'(j);
            check("sram byte", {24'h0, sram_byte(a)}, {24'h0, ref_mem[a]});
        end
    endtask

    task automatic read_check(acc_size_e size, ea_src_e src, logic [ADDR_W-1:0] addr);
        int          beats;
        int          busy_cycles;
        int          exp_beats;
        logic        hit;
        logic [31:0] exp;
        hit       = (addr == cached_addr) && (size == cached_size);
        exp_beats = hit ? 0 : beat_count(size, addr[0]);
        exp       = last_mdata;
        if (!hit) begin
            exp = '0;
            for (int i = 0; i < size_bytes(size); i++) begin
                exp[8*i +: 8] = ref_mem[16'(addr + ADDR_W'(i))];    // little-endian
            end
            cached_addr = addr;
            cached_size = size;
            if (src == src_pc) begin
                exp_pc = exp_pc + ADDR_W'(size_bytes(size));
            end
        end
        run_access(1'b0, size, src, beats, busy_cycles);
        check("read beats", beats, exp_beats);
        check("read busy cycles", busy_cycles, hit ? 0 : 1 + exp_beats * (1 + WAIT_CYCLES));
        check("mdata", mdata, exp);
        check("pc", {8'h00, pc}, {8'h00, exp_pc});
        last_mdata = exp;
    endtask

    task automatic random_write(acc_size_e size, logic odd);
        logic [31:0] r;
        r = rand_word();
        write_check(size, {8'h00, r[15:1], odd}, rand_word());
    endtask

    task automatic sp_read(acc_size_e size, logic [1:0] off);
        logic [31:0] r;
        r = rand_word();
        load_reg(r_sp, {16'h0000, r[15:2], off});
        read_check(size, src_sp, {8'h00, r[15:2], off});
    endtask

    task automatic cache_reuse();
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        r = rand_word();
        a = {8'h00, r[15:1], 1'b1};    // odd quad takes three beats
        load_reg(r_sp, {8'h00, a});
        read_check(sz_quad, src_sp, a);
        read_check(sz_quad, src_sp, a);    // same pair so no bus traffic
        write_check(sz_quad, a, ~r);
        read_check(sz_quad, src_sp, a);
    endtask

    task automatic pc_fetch();
        logic [31:0] r;
        r = rand_word();
        load_reg(r_pc, {16'h0000, r[15:1], 1'b0});
        exp_pc = {8'h00, r[15:1], 1'b0};
        repeat (3) begin
            read_check(sz_quad, src_pc, exp_pc);
        end
        read_check(sz_byte, src_pc, exp_pc);
    endtask

    task automatic ea_copy();
        logic [31:0] r;
        r = rand_word();
        load_reg(r_da, r);
        next_cycle();
        req.da2ea = 1'b1;
        next_cycle();
        req.da2ea = 1'b0;
        check("ea", ea, r);
        load_reg(r_da, ~r);    // da moves away so the read has to use ea
        check("ea after da reload", ea, r);
        read_check(sz_word, src_ea, r[ADDR_W-1:0]);
    endtask

    initial begin
        req      = '0;
        reg_load = '0;
        rst      = 1'b1;
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = fill_byte(16'(a));
        end
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        for (int s = 0; s < 3; s++) begin
            random_write(acc_size_e'(s), 1'b0);
            random_write(acc_size_e'(s), 1'b1);
        end
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off++) begin
                sp_read(acc_size_e'(s), 2'(off));
            end
        end
        cache_reuse();
        pc_fetch();
        ea_copy();
        $display("Verification passed");
        $finish;
    end

    // 200 cycles per test call plus reset
    initial begin
        #((N_TEST_CALLS * 200 + 10) * CLK_PERIOD);
        $display("watchdog timeout: the tests did not finish in time");
        $display("Verification failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: list.f
rtl/mem_bus_pkg.sv
rtl/mem_uop_pkg.sv
rtl/operand_regs.sv
rtl/mem_access.sv
rtl/wait_state_gen.sv
rtl/mem_subsys_top.sv
tb/sram_model.sv
tb/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f list.f --top-module tb_mem_subsys -o tb_mem_subsys

./obj_dir/tb_mem_subsys | tee sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
fi
exit 1
